//--- hw/tcdm_pkg.sv
// Shared TCDM widths, vector types and issue FSM states, referenced by scoped name everywhere.
package tcdm_pkg;

  // Word address width.
  // 256 words in the single bank.
  localparam int unsigned AddrWidth = 8;

  // Data word width in bits.
  localparam int unsigned DataWidth = 32;

  // One byte-enable bit per byte of the data word.
  localparam int unsigned BeWidth = 4;

  // Width of one byte lane.
  localparam int unsigned ByteWidth = DataWidth / BeWidth;

  // Number of words held by the bank.
  localparam int unsigned BankWords = 2 ** AddrWidth;

  // Width of the read response counter.
  // It wraps at this width.
  localparam int unsigned CountWidth = 16;

  // Word address on the TCDM request.
  typedef logic [AddrWidth-1:0] tcdm_addr_t;

  // Write data and read data word.
  typedef logic [DataWidth-1:0] tcdm_data_t;

  // Byte enables of a write.
  typedef logic [BeWidth-1:0] tcdm_be_t;

  // Captured response count.
  typedef logic [CountWidth-1:0] rsp_count_t;

  // Request stage states.
  // IDLE has nothing pending.
  // WAIT holds a request until the bank grants it.
  typedef enum logic {
    ISSUE_IDLE = 1'b0,
    ISSUE_WAIT = 1'b1
  } issue_state_e;

endpackage

//--- hw/tcdm_req_issue.sv
// Request stage that turns command strobes into a held TCDM request, one command per cycle.
`timescale 1ns/1ns

module tcdm_req_issue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  logic                 cmd_write_i,
  input  tcdm_pkg::tcdm_addr_t cmd_addr_i,
  input  tcdm_pkg::tcdm_data_t cmd_wdata_i,
  input  tcdm_pkg::tcdm_be_t   cmd_be_i,
  input  logic                 gnt_i,
  output logic                 cmd_ready_o,
  output logic                 req_o,
  output logic                 wen_o,
  output tcdm_pkg::tcdm_addr_t add_o,
  output tcdm_pkg::tcdm_data_t data_o,
  output tcdm_pkg::tcdm_be_t   be_o
);

  tcdm_pkg::issue_state_e state_q;
  tcdm_pkg::issue_state_e state_d;

  // Command taken this cycle.
  logic accept;

  // Held request fields.
  logic                 wen_q;
  tcdm_pkg::tcdm_addr_t add_q;
  tcdm_pkg::tcdm_data_t data_q;
  tcdm_pkg::tcdm_be_t   be_q;

  // Ready when nothing is pending.
  // Also ready in the cycle the pending request is granted, so a new
  // command chains directly behind it.
  assign cmd_ready_o = (state_q == tcdm_pkg::ISSUE_IDLE) || gnt_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tcdm_pkg::ISSUE_IDLE: begin
        if (accept) begin
          state_d = tcdm_pkg::ISSUE_WAIT;
        end
      end
      tcdm_pkg::ISSUE_WAIT: begin
        // Grant without a chained command empties the stage.
        if (gnt_i && !accept) begin
          state_d = tcdm_pkg::ISSUE_IDLE;
        end
      end
      default: begin
        state_d = tcdm_pkg::ISSUE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tcdm_pkg::ISSUE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields load on acceptance only.
  // They stay stable while the request waits for its grant.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      // TCDM wen is high for a read.
      wen_q  <= !cmd_write_i;
      add_q  <= cmd_addr_i;
      data_q <= cmd_wdata_i;
      be_q   <= cmd_be_i;
    end
  end

  assign req_o  = (state_q == tcdm_pkg::ISSUE_WAIT);
  assign wen_o  = wen_q;
  assign add_o  = add_q;
  assign data_o = data_q;
  assign be_o   = be_q;

endmodule

//--- hw/tcdm_bank.sv
// Single-cycle word bank with a core port and a priority external port, byte-enabled writes.
`timescale 1ns/1ns

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 wen_i,
  input  tcdm_pkg::tcdm_addr_t add_i,
  input  tcdm_pkg::tcdm_data_t data_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  logic                 ext_req_i,
  input  logic                 ext_wen_i,
  input  tcdm_pkg::tcdm_addr_t ext_addr_i,
  input  tcdm_pkg::tcdm_data_t ext_wdata_i,
  input  tcdm_pkg::tcdm_be_t   ext_be_i,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output tcdm_pkg::tcdm_data_t r_data_o,
  output logic                 ext_gnt_o,
  output tcdm_pkg::tcdm_data_t ext_rdata_o
);

  // Word storage.
  tcdm_pkg::tcdm_data_t mem_q [tcdm_pkg::BankWords];

  // Fields of the port served this cycle.
  logic                 served;
  logic                 sel_wen;
  tcdm_pkg::tcdm_addr_t sel_addr;
  tcdm_pkg::tcdm_data_t sel_wdata;
  tcdm_pkg::tcdm_be_t   sel_be;

  // Read word, shared by both ports.
  // Only one port is served per cycle.
  tcdm_pkg::tcdm_data_t rdata_q;
  logic                 r_valid_q;

  // External port always wins.
  assign ext_gnt_o = ext_req_i;
  assign gnt_o     = req_i && !ext_req_i;

  assign served    = ext_req_i || req_i;
  assign sel_wen   = ext_req_i ? ext_wen_i   : wen_i;
  assign sel_addr  = ext_req_i ? ext_addr_i  : add_i;
  assign sel_wdata = ext_req_i ? ext_wdata_i : data_i;
  assign sel_be    = ext_req_i ? ext_be_i    : be_i;

  // Writes merge the enabled byte lanes into the stored word.
  always_ff @(posedge clk_i) begin
    if (served && !sel_wen) begin
      for (int unsigned i = 0; i < tcdm_pkg::BeWidth; i++) begin
        if (sel_be[i]) begin
          mem_q[sel_addr][i*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth] <=
            sel_wdata[i*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth];
        end
      end
    end
  end

  // Reads register the word; the value holds until the next read.
  always_ff @(posedge clk_i) begin
    if (served && sel_wen) begin
      rdata_q <= mem_q[sel_addr];
    end
  end

  // Every core grant, read or write, is answered one cycle later.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt_o;
    end
  end

  assign r_valid_o   = r_valid_q;
  assign r_data_o    = rdata_q;
  // Fixed latency, so no separate valid on the external side.
  assign ext_rdata_o = rdata_q;

endmodule

//--- hw/tcdm_r_valid_filter.sv
// Sits between request stage and bank; drops write response valids when enabled.
`timescale 1ns/1ns

module tcdm_r_valid_filter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 enable_i,
  input  logic                 req_i,
  input  logic                 wen_i,
  input  tcdm_pkg::tcdm_addr_t add_i,
  input  tcdm_pkg::tcdm_data_t data_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  logic                 gnt_i,
  input  logic                 r_valid_i,
  input  tcdm_pkg::tcdm_data_t r_data_i,
  output logic                 req_o,
  output logic                 wen_o,
  output tcdm_pkg::tcdm_addr_t add_o,
  output tcdm_pkg::tcdm_data_t data_o,
  output tcdm_pkg::tcdm_be_t   be_o,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output tcdm_pkg::tcdm_data_t r_data_o
);

  // wen of the last request seen while enabled.
  // Only valid with exactly one cycle from grant to response.
  logic wen_q;

  // Request path goes straight through.
  assign req_o  = req_i;
  assign wen_o  = wen_i;
  assign add_o  = add_i;
  assign data_o = data_i;
  assign be_o   = be_i;

  // Response path; only the valid is touched.
  assign gnt_o     = gnt_i;
  assign r_data_o  = r_data_i;
  assign r_valid_o = enable_i ? (r_valid_i && wen_q) : r_valid_i;

  // A stalled request rewrites the same value each cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wen_q <= 1'b0;
    end else if (clear_i) begin
      wen_q <= 1'b0;
    end else if (enable_i && req_i) begin
      wen_q <= wen_i;
    end
  end

endmodule

//--- hw/tcdm_resp_capture.sv
// Result stage: registers read data on each filtered response and counts the responses.
`timescale 1ns/1ns

module tcdm_resp_capture (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 r_valid_i,
  input  tcdm_pkg::tcdm_data_t r_data_i,
  output logic                 rsp_valid_o,
  output tcdm_pkg::tcdm_data_t rsp_data_o,
  output tcdm_pkg::rsp_count_t rd_count_o
);

  logic                 rsp_valid_q;
  tcdm_pkg::tcdm_data_t rsp_data_q;
  tcdm_pkg::rsp_count_t rd_count_q;

  // One-cycle pulse per response.
  // Clear suppresses it.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (clear_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= r_valid_i;
    end
  end

  // Counter wraps naturally at its width.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_count_q <= '0;
    end else if (clear_i) begin
      rd_count_q <= '0;
    end else if (r_valid_i) begin
      rd_count_q <= rd_count_q + tcdm_pkg::rsp_count_t'(1);
    end
  end

  // Last response word.
  // Held between responses.
  always_ff @(posedge clk_i) begin
    if (r_valid_i) begin
      rsp_data_q <= r_data_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;
  assign rd_count_o  = rd_count_q;

endmodule

//--- hw/tcdm_subsys.sv
// Top level of the TCDM subsystem: request stage, response filter, bank and capture stage.
`timescale 1ns/1ns

module tcdm_subsys (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 enable_i,
  input  logic                 cmd_valid_i,
  input  logic                 cmd_write_i,
  input  tcdm_pkg::tcdm_addr_t cmd_addr_i,
  input  tcdm_pkg::tcdm_data_t cmd_wdata_i,
  input  tcdm_pkg::tcdm_be_t   cmd_be_i,
  output logic                 cmd_ready_o,
  input  logic                 ext_req_i,
  input  logic                 ext_wen_i,
  input  tcdm_pkg::tcdm_addr_t ext_addr_i,
  input  tcdm_pkg::tcdm_data_t ext_wdata_i,
  input  tcdm_pkg::tcdm_be_t   ext_be_i,
  output logic                 ext_gnt_o,
  output tcdm_pkg::tcdm_data_t ext_rdata_o,
  output logic                 rsp_valid_o,
  output tcdm_pkg::tcdm_data_t rsp_data_o,
  output tcdm_pkg::rsp_count_t rd_count_o
);

  // Request stage side of the filter.
  logic                 issue_req;
  logic                 issue_wen;
  tcdm_pkg::tcdm_addr_t issue_add;
  tcdm_pkg::tcdm_data_t issue_data;
  tcdm_pkg::tcdm_be_t   issue_be;
  logic                 issue_gnt;
  logic                 flt_r_valid;
  tcdm_pkg::tcdm_data_t flt_r_data;

  // Bank side of the filter.
  logic                 bank_req;
  logic                 bank_wen;
  tcdm_pkg::tcdm_addr_t bank_add;
  tcdm_pkg::tcdm_data_t bank_data;
  tcdm_pkg::tcdm_be_t   bank_be;
  logic                 bank_gnt;
  logic                 bank_r_valid;
  tcdm_pkg::tcdm_data_t bank_r_data;

  tcdm_req_issue u_req_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_write_i (cmd_write_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_be_i    (cmd_be_i),
    .gnt_i       (issue_gnt),
    .cmd_ready_o (cmd_ready_o),
    .req_o       (issue_req),
    .wen_o       (issue_wen),
    .add_o       (issue_add),
    .data_o      (issue_data),
    .be_o        (issue_be)
  );

  tcdm_r_valid_filter u_r_valid_filter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .enable_i  (enable_i),
    .req_i     (issue_req),
    .wen_i     (issue_wen),
    .add_i     (issue_add),
    .data_i    (issue_data),
    .be_i      (issue_be),
    .gnt_i     (bank_gnt),
    .r_valid_i (bank_r_valid),
    .r_data_i  (bank_r_data),
    .req_o     (bank_req),
    .wen_o     (bank_wen),
    .add_o     (bank_add),
    .data_o    (bank_data),
    .be_o      (bank_be),
    .gnt_o     (issue_gnt),
    .r_valid_o (flt_r_valid),
    .r_data_o  (flt_r_data)
  );

  tcdm_bank u_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (bank_req),
    .wen_i       (bank_wen),
    .add_i       (bank_add),
    .data_i      (bank_data),
    .be_i        (bank_be),
    .ext_req_i   (ext_req_i),
    .ext_wen_i   (ext_wen_i),
    .ext_addr_i  (ext_addr_i),
    .ext_wdata_i (ext_wdata_i),
    .ext_be_i    (ext_be_i),
    .gnt_o       (bank_gnt),
    .r_valid_o   (bank_r_valid),
    .r_data_o    (bank_r_data),
    .ext_gnt_o   (ext_gnt_o),
    .ext_rdata_o (ext_rdata_o)
  );

  tcdm_resp_capture u_resp_capture (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .r_valid_i   (flt_r_valid),
    .r_data_i    (flt_r_data),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rd_count_o  (rd_count_o)
  );

endmodule

//--- verif/tcdm_subsys_properties.sv
// Checker bound into the TCDM top level; asserts bank grant/response timing and write filtering.
`timescale 1ns/1ns

module tcdm_subsys_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic enable_i,
  input logic ext_req_i,
  input logic bank_req,
  input logic bank_wen,
  input logic bank_gnt,
  input logic bank_r_valid,
  input logic flt_r_valid
);

  // Fixed latency.
  // One bank response per core grant, one cycle later.
  r_valid_follows_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bank_r_valid == $past(bank_gnt)
  ) else $error("bank r_valid does not match the core grant of the previous cycle");

  // External port has priority, and a grant needs a core request.
  gnt_needs_free_bank: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bank_gnt |-> (bank_req && !ext_req_i)
  ) else $error("core grant while the external port requests or without a core request");

  // Write responses never reach the capture stage while the filter is on.
  write_rsp_dropped: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ($past(enable_i) && enable_i && $past(bank_gnt) && !$past(bank_wen)) |-> !flt_r_valid
  ) else $error("filtered r_valid raised for a granted write");

endmodule

//--- verif/tcdm_subsys_tb.sv
// Testbench for the TCDM subsystem; drives commands and external bursts, checks every response.
`timescale 1ns/1ns

module tcdm_subsys_tb;

  // Commands over all phases; the run limit scales with it.
  localparam int num_cmds       = 98;
  localparam int timeout_cycles = 4 * num_cmds + 200;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 clear_i;
  logic                 enable_i;
  logic                 cmd_valid_i;
  logic                 cmd_write_i;
  tcdm_pkg::tcdm_addr_t cmd_addr_i;
  tcdm_pkg::tcdm_data_t cmd_wdata_i;
  tcdm_pkg::tcdm_be_t   cmd_be_i;
  logic                 cmd_ready_o;
  logic                 ext_req_i   = 1'b0;
  logic                 ext_wen_i   = 1'b1;
  tcdm_pkg::tcdm_addr_t ext_addr_i  = '0;
  tcdm_pkg::tcdm_data_t ext_wdata_i = '0;
  tcdm_pkg::tcdm_be_t   ext_be_i    = '0;
  logic                 ext_gnt_o;
  tcdm_pkg::tcdm_data_t ext_rdata_o;
  logic                 rsp_valid_o;
  tcdm_pkg::tcdm_data_t rsp_data_o;
  tcdm_pkg::rsp_count_t rd_count_o;

  int   seed       = 32'h409ba1f9;
  int   ext_seed;
  int   cycle      = 0;
  int   burst      = 0;
  logic ext_on     = 1'b0;
  int   data_errs  = 0;
  int   count_errs = 0;
  int   flag_errs  = 0;
  int   other_errs = 0;

  // Reference model state.
  tcdm_pkg::tcdm_data_t ref_mem [tcdm_pkg::BankWords];
  tcdm_pkg::tcdm_data_t last_rd;
  tcdm_pkg::tcdm_data_t ext_exp;
  logic                 ext_chk = 1'b0;
  logic                 pend    = 1'b0;
  logic                 p_wen;
  tcdm_pkg::tcdm_addr_t p_addr;
  tcdm_pkg::tcdm_data_t p_wdata;
  tcdm_pkg::tcdm_be_t   p_be;
  tcdm_pkg::tcdm_data_t exp_data_q [$];
  int                   exp_cyc_q  [$];

  tcdm_subsys u_tcdm_subsys (.*);

  bind tcdm_subsys tcdm_subsys_properties u_properties (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (enable_i),
    .ext_req_i    (ext_req_i),
    .bank_req     (bank_req),
    .bank_wen     (bank_wen),
    .bank_gnt     (bank_gnt),
    .bank_r_valid (bank_r_valid),
    .flt_r_valid  (flt_r_valid)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // Byte-enable merge of a write into the old word.
  function automatic tcdm_pkg::tcdm_data_t merge_be(input tcdm_pkg::tcdm_data_t old_word,
      input tcdm_pkg::tcdm_data_t new_word, input tcdm_pkg::tcdm_be_t be);
    tcdm_pkg::tcdm_data_t word;
    word = old_word;
    for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
      if (be[b]) begin
        word[b*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth] =
          new_word[b*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth];
      end
    end
    return word;
  endfunction

  // Words 0 to 15 only, so every read hits a written word.
  function automatic tcdm_pkg::tcdm_addr_t rand_addr();
    return tcdm_pkg::tcdm_addr_t'($random(seed) & 15);
  endfunction

  function automatic tcdm_pkg::tcdm_data_t rand_data();
    return tcdm_pkg::tcdm_data_t'($random(seed));
  endfunction

  task automatic check_data(input string name, input tcdm_pkg::tcdm_data_t exp,
                            input tcdm_pkg::tcdm_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input tcdm_pkg::rsp_count_t exp,
                             input tcdm_pkg::rsp_count_t act);
    if (act !== exp) begin
      count_errs++;
      $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Presents one command and returns at the edge that takes it.
  task automatic send_cmd(input logic wr, input tcdm_pkg::tcdm_addr_t addr,
                          input tcdm_pkg::tcdm_data_t wdata, input tcdm_pkg::tcdm_be_t be);
    cmd_valid_i <= 1'b1;
    cmd_write_i <= wr;
    cmd_addr_i  <= addr;
    cmd_wdata_i <= wdata;
    cmd_be_i    <= be;
    do begin
      @(posedge clk_i);
    end while (!cmd_ready_o);
  endtask

  // Drops the strobe and waits for the grant of the last request.
  // Its answer follows two cycles after that grant.
  task automatic drain(input int exp_count);
    cmd_valid_i <= 1'b0;
    do begin
      @(posedge clk_i);
    end while (!cmd_ready_o);
    repeat (3) @(posedge clk_i);
    if (exp_data_q.size() != 0) begin
      other_errs++;
      $display("%0d expected responses were never seen", exp_data_q.size());
      exp_data_q.delete();
      exp_cyc_q.delete();
    end
    check_count("rd_count_o", tcdm_pkg::rsp_count_t'(exp_count), rd_count_o);
  endtask

  task automatic pulse_clear();
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(posedge clk_i);
  endtask

  // External bursts of one to four cycles, random reads and writes.
  always @(posedge clk_i) begin
    if (burst == 0 && ext_on && ($random(ext_seed) & 7) == 0) begin
      burst = ($random(ext_seed) & 3) + 1;
    end
    ext_req_i   <= ext_on && burst != 0;
    ext_wen_i   <= 1'($random(ext_seed));
    ext_addr_i  <= tcdm_pkg::tcdm_addr_t'($random(ext_seed) & 15);
    ext_wdata_i <= tcdm_pkg::tcdm_data_t'($random(ext_seed));
    ext_be_i    <= tcdm_pkg::tcdm_be_t'($random(ext_seed));
    if (burst != 0) begin
      burst = burst - 1;
    end
  end

  // Reference model.
  // External port wins the bank; a pending core request goes when it is free.
  always @(posedge clk_i) begin
    // The external port is granted whenever it requests.
    check_flag("ext_gnt_o", ext_req_i, ext_gnt_o);
    if (ext_chk) begin
      check_data("ext_rdata_o", ext_exp, ext_rdata_o);
    end
    ext_chk = 1'b0;
    if (ext_req_i) begin
      if (ext_wen_i) begin
        ext_chk = 1'b1;
        ext_exp = ref_mem[ext_addr_i];
        last_rd = ext_exp;
      end else begin
        ref_mem[ext_addr_i] = merge_be(ref_mem[ext_addr_i], ext_wdata_i, ext_be_i);
      end
    end else if (pend) begin
      pend = 1'b0;
      if (p_wen) begin
        last_rd = ref_mem[p_addr];
      end else begin
        ref_mem[p_addr] = merge_be(ref_mem[p_addr], p_wdata, p_be);
      end
      // A write answers with the stale read word when the filter is off.
      if (p_wen || !enable_i) begin
        exp_data_q.push_back(last_rd);
        exp_cyc_q.push_back(cycle + 2);
      end
    end
    if (cmd_valid_i && cmd_ready_o) begin
      pend    = 1'b1;
      p_wen   = !cmd_write_i;
      p_addr  = cmd_addr_i;
      p_wdata = cmd_wdata_i;
      p_be    = cmd_be_i;
    end
  end

  // Compare process.
  always @(posedge clk_i) begin
    int exp_cyc;
    if (rsp_valid_o) begin
      if (exp_data_q.size() == 0) begin
        other_errs++;
        $display("Response at cycle %0d with no command waiting for it", cycle);
      end else begin
        check_data("rsp_data_o", exp_data_q.pop_front(), rsp_data_o);
        exp_cyc = exp_cyc_q.pop_front();
        if (exp_cyc != cycle) begin
          other_errs++;
          $display("Response at cycle %0d, expected at cycle %0d", cycle, exp_cyc);
        end
      end
    end
  end

  initial begin
    wait (cycle >= timeout_cycles);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Error counts: data %0d, count %0d, flag %0d, other %0d",
             data_errs, count_errs, flag_errs, other_errs);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int   n_rd;
    int   start;
    logic wr;
    ext_seed    = $random(seed);
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    enable_i    = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_write_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_wdata_i = '0;
    cmd_be_i    = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Filter on: full writes define words 0 to 15, then only reads answer.
    for (int i = 0; i < 16; i++) begin
      send_cmd(1'b1, tcdm_pkg::tcdm_addr_t'(i), rand_data(), 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      send_cmd(1'b0, tcdm_pkg::tcdm_addr_t'(i), '0, '0);
    end
    drain(16);

    // Filter off, so the count covers writes as well.
    pulse_clear();
    enable_i <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      send_cmd(i < 8, rand_addr(), rand_data(), tcdm_pkg::tcdm_be_t'($random(seed)));
    end
    drain(16);

    // External bursts stall the core port.
    pulse_clear();
    enable_i <= 1'b1;
    ext_on   <= 1'b1;
    n_rd = 0;
    for (int i = 0; i < 32; i++) begin
      wr = 1'($random(seed));
      if (!wr) begin
        n_rd++;
      end
      send_cmd(wr, rand_addr(), rand_data(), tcdm_pkg::tcdm_be_t'($random(seed)));
    end
    ext_on <= 1'b0;
    drain(n_rd);

    // Strobe held high, one read taken per cycle.
    start = cycle;
    for (int i = 0; i < 16; i++) begin
      send_cmd(1'b0, rand_addr(), '0, '0);
    end
    if (cycle - start != 16) begin
      other_errs++;
      $display("Back-to-back reads took %0d cycles for 16 commands", cycle - start);
    end
    drain(n_rd + 16);

    // Last request before clear is a write; the read after it must still answer.
    send_cmd(1'b1, 8'd3, rand_data(), 4'h5);
    drain(n_rd + 16);
    pulse_clear();
    check_count("rd_count_o", '0, rd_count_o);
    send_cmd(1'b0, 8'd3, '0, '0);
    drain(1);

    $display("Error counts: data %0d, count %0d, flag %0d, other %0d",
             data_errs, count_errs, flag_errs, other_errs);
    if (data_errs + count_errs + flag_errs + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tcdm_subsys.f
hw/tcdm_pkg.sv
hw/tcdm_req_issue.sv
hw/tcdm_bank.sv
hw/tcdm_r_valid_filter.sv
hw/tcdm_resp_capture.sv
hw/tcdm_subsys.sv
verif/tcdm_subsys_properties.sv
verif/tcdm_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the TCDM subsystem testbench with Verilator, runs it and checks the log.
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tcdm_subsys_tb \
  -f tcdm_subsys.f \
  -o tcdm_subsys_sim

./obj_dir/tcdm_subsys_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
